/* verilog/z80_pkg.sv */
// Z80 side constants: bus widths, memory windows, page port
// and the page table contents after reset

`default_nettype none

package z80_pkg;

	// cpu bus
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// 64K space split into 16K windows
	localparam int WIN_BITS = 2;
	localparam int WINDOWS  = 1 << WIN_BITS;

	// one page register per window, window 0 is the ROM
	localparam int PAGE_W = 8;

	// port low byte that loads a page register
	localparam logic [7:0] PAGE_PORT = 8'hF7;

	// pages for windows 3..1 after reset
	// window 1 -> 5, window 2 -> 2, window 3 -> 0
	localparam logic [WINDOWS-1:1][PAGE_W-1:0] RESET_PAGES = {
		8'd0,
		8'd2,
		8'd5
	};

endpackage

`default_nettype wire

/* verilog/dram_pkg.sv */
// DRAM side constants: byte address split, data bus width
// and the queued write command

`default_nettype none

package dram_pkg;

	// 4M bytes over two 16-bit banks
	localparam int BADDR_W = 22;
	localparam int MA_W    = 10;
	localparam int DQ_W    = 16;
	localparam int BYTE_W  = DQ_W / 2;

	// byte address layout
	// row 21..12, column 11..2, chip select 1, byte select 0
	localparam int ROW_LSB  = 12;
	localparam int COL_LSB  = 2;
	localparam int CHIP_BIT = 1;
	localparam int BYTE_BIT = 0;

	// one byte write, as queued between capture and writer
	typedef struct packed {
		logic [BADDR_W-1:0] addr;
		logic [BYTE_W-1:0]  data;
	} wr_cmd_t;

endpackage

`default_nettype wire

/* verilog/z80_bus_capture.sv */
// Z80 strobe synchronizer, write decoder, page table
// and mapping of memory writes to DRAM byte addresses

`timescale 1ns/1ns
`default_nettype none

module z80_bus_capture
(
	input  wire                          fclk,
	input  wire                          rst_n,

	input  wire                          mreq_n,
	input  wire                          iorq_n,
	input  wire                          wr_n,
	input  wire  [z80_pkg::ADDR_W-1:0]   a,
	input  wire  [z80_pkg::DATA_W-1:0]   d,

	input  wire                          full,
	output logic                         push,
	output dram_pkg::wr_cmd_t            push_cmd,
	output logic                         wait_n
);

	// offset bits inside one 16K window
	localparam int OFS_W = z80_pkg::ADDR_W - z80_pkg::WIN_BITS;

	// [0],[1] synchronizer stages, [2] previous synced sample
	logic [2:0] mreq_sr;
	logic [2:0] iorq_sr;
	logic [2:0] wr_sr;

	logic [z80_pkg::ADDR_W-1:0] a_q;
	logic [z80_pkg::DATA_W-1:0] d_q;

	logic [z80_pkg::WIN_BITS-1:0] win;
	logic wr_rise;
	logic page_wr;
	logic mem_req;

	// command waiting for room in the FIFO
	logic pend;

	logic [z80_pkg::WINDOWS-1:1][z80_pkg::PAGE_W-1:0] page;

	// strobes are async to fclk
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			mreq_sr <= '1;
			iorq_sr <= '1;
			wr_sr   <= '1;
		end
		else
		begin
			mreq_sr <= {mreq_sr[1:0], mreq_n};
			iorq_sr <= {iorq_sr[1:0], iorq_n};
			wr_sr   <= {wr_sr[1:0], wr_n};
		end
	end

	// bus is stable while synced wr_n low
	always_ff @(posedge fclk)
	begin
		if (!wr_sr[1])
		begin
			a_q <= a;
			d_q <= d;
		end
	end

	// end of write cycle, classified by the sample before it
	assign wr_rise = wr_sr[1] & ~wr_sr[2];
	assign win     = a_q[z80_pkg::ADDR_W-1 -: z80_pkg::WIN_BITS];

	assign page_wr = wr_rise & ~iorq_sr[2] & (a_q[7:0] == z80_pkg::PAGE_PORT) & (win != '0);
	// ROM window writes fall out here
	assign mem_req = wr_rise & ~mreq_sr[2] & (win != '0);

	// page registers, window 0 has none
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			page <= z80_pkg::RESET_PAGES;
		else if (page_wr)
			page[win] <= d_q;
	end

	// command register
	always_ff @(posedge fclk)
	begin
		if (mem_req)
		begin
			push_cmd.addr <= {page[win], a_q[OFS_W-1:0]};
			push_cmd.data <= d_q;
		end
	end

	// push now, or park until full drops
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			push <= 1'b0;
			pend <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (mem_req)
			begin
				if (full)
					pend <= 1'b1;
				else
					push <= 1'b1;
			end
			else if (pend && !full)
			begin
				push <= 1'b1;
				pend <= 1'b0;
			end
		end
	end

	// stall the next bus cycle while a command is parked
	assign wait_n = ~pend;

endmodule

`default_nettype wire

/* verilog/cmd_fifo.sv */
// command FIFO between bus capture and DRAM writer
// circular buffer with full and empty from extended pointers

`timescale 1ns/1ns
`default_nettype none

module cmd_fifo
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  wire                    fclk,
	input  wire                    rst_n,

	input  wire                    push,
	input  wire dram_pkg::wr_cmd_t push_cmd,

	input  wire                    pop,
	output dram_pkg::wr_cmd_t      pop_cmd,

	output logic                   full,
	output logic                   empty
);

	localparam int IDX_W = $clog2(FIFO_DEPTH);

	dram_pkg::wr_cmd_t mem [FIFO_DEPTH];

	// extra msb tells wrap parity
	logic [IDX_W:0] wr_ptr;
	logic [IDX_W:0] rd_ptr;

	logic do_push;
	logic do_pop;

	// strobes outside the legal state are ignored
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge fclk)
	begin
		if (do_push)
			mem[wr_ptr[IDX_W-1:0]] <= push_cmd;
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// head straight out of the register array
	assign pop_cmd = mem[rd_ptr[IDX_W-1:0]];

	// same index and wrap parity decides full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]) &&
	               (wr_ptr[IDX_W] != rd_ptr[IDX_W]);

endmodule

`default_nettype wire

/* verilog/dram_writer.sv */
// DRAM write sequencer with IDLE/RAS/CAS/PRE per queued byte
// strobes and address registered straight to the pins

`timescale 1ns/1ns
`default_nettype none

module dram_writer
(
	input  wire                          fclk,
	input  wire                          rst_n,

	input  wire                          empty,
	input  wire dram_pkg::wr_cmd_t       pop_cmd,
	output logic                         pop,

	output logic [dram_pkg::MA_W-1:0]    ra,
	output logic [dram_pkg::DQ_W-1:0]    rd,
	output logic                         rwe_n,
	output logic                         rucas_n,
	output logic                         rlcas_n,
	output logic                         rras0_n,
	output logic                         rras1_n
);

	typedef enum logic [1:0] {
		IDLE,
		RAS,
		CAS,
		PRE
	} state_t;

	state_t state;

	// popped command for the column phase
	dram_pkg::wr_cmd_t cmd_q;

	// take the head whenever idle
	assign pop = (state == IDLE) & ~empty;

	// row then column on ra, data lanes
	always_ff @(posedge fclk)
	begin
		if (pop)
		begin
			cmd_q <= pop_cmd;
			ra    <= pop_cmd.addr[dram_pkg::ROW_LSB +: dram_pkg::MA_W];
		end
		else if (state == RAS)
		begin
			ra <= cmd_q.addr[dram_pkg::COL_LSB +: dram_pkg::MA_W];
			// byte on both halves while cas picks the lane
			rd <= {2{cmd_q.data}};
		end
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			state   <= IDLE;
			rwe_n   <= 1'b1;
			rucas_n <= 1'b1;
			rlcas_n <= 1'b1;
			rras0_n <= 1'b1;
			rras1_n <= 1'b1;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (pop)
					begin
						// chip select bit picks the bank
						rras0_n <= pop_cmd.addr[dram_pkg::CHIP_BIT];
						rras1_n <= ~pop_cmd.addr[dram_pkg::CHIP_BIT];
						state   <= RAS;
					end
				end
				RAS:
				begin
					// ras stays low through cas
					rwe_n   <= 1'b0;
					rucas_n <= cmd_q.addr[dram_pkg::BYTE_BIT];
					rlcas_n <= ~cmd_q.addr[dram_pkg::BYTE_BIT];
					state   <= CAS;
				end
				CAS:
				begin
					// precharge with all strobes high
					rwe_n   <= 1'b1;
					rucas_n <= 1'b1;
					rlcas_n <= 1'b1;
					rras0_n <= 1'b1;
					rras1_n <= 1'b1;
					state   <= PRE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/z80_dram_bridge.sv */
// top level of the Z80 to DRAM write path
// bus capture, command FIFO and DRAM writer

`timescale 1ns/1ns
`default_nettype none

module z80_dram_bridge
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  wire                       fclk,
	input  wire                       rst_n,

	// z80 bus
	input  wire                       mreq_n,
	input  wire                       iorq_n,
	input  wire                       wr_n,
	input  wire  [15:0]               a,
	input  wire  [7:0]                d,
	output logic                      wait_n,

	// dram pins
	output logic [9:0]                ra,
	output logic [15:0]               rd,
	output logic                      rwe_n,
	output logic                      rucas_n,
	output logic                      rlcas_n,
	output logic                      rras0_n,
	output logic                      rras1_n
);

	// capture to fifo
	logic              push;
	dram_pkg::wr_cmd_t push_cmd;
	logic              full;

	// fifo to writer
	logic              pop;
	dram_pkg::wr_cmd_t pop_cmd;
	logic              empty;

	z80_bus_capture i_z80_bus_capture (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.a        (a),
		.d        (d),
		.full     (full),
		.push     (push),
		.push_cmd (push_cmd),
		.wait_n   (wait_n)
	);

	cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_cmd_fifo (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.push     (push),
		.push_cmd (push_cmd),
		.pop      (pop),
		.pop_cmd  (pop_cmd),
		.full     (full),
		.empty    (empty)
	);

	dram_writer i_dram_writer (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.empty    (empty),
		.pop_cmd  (pop_cmd),
		.pop      (pop),
		.ra       (ra),
		.rd       (rd),
		.rwe_n    (rwe_n),
		.rucas_n  (rucas_n),
		.rlcas_n  (rlcas_n),
		.rras0_n  (rras0_n),
		.rras1_n  (rras1_n)
	);

endmodule

`default_nettype wire

/* sim/dram_model.sv */
// two-bank DRAM model, rebuilds byte writes from RAS/CAS
// and reports each one as a byte address and a data byte

`timescale 1ns/1ns
`default_nettype none

module dram_model
(
	input  wire                           fclk,
	input  wire                           rst_n,

	input  wire  [dram_pkg::MA_W-1:0]     ra,
	input  wire  [dram_pkg::DQ_W-1:0]     rd,
	input  wire                           rwe_n,
	input  wire                           rucas_n,
	input  wire                           rlcas_n,
	input  wire                           rras0_n,
	input  wire                           rras1_n,

	output logic                          rep_valid,
	output logic [dram_pkg::BADDR_W-1:0]  rep_addr,
	output logic [7:0]                    rep_data
);

	logic [dram_pkg::MA_W-1:0] row;
	logic                      chip;

	always @(posedge fclk)
	begin
		if (!rst_n)
			rep_valid <= 1'b0;
		else
		begin
			rep_valid <= 1'b0;
			if (!rras0_n || !rras1_n)
			begin
				if (rucas_n && rlcas_n)
				begin
					// row phase, bank from the ras that fell
					row  <= ra;
					chip <= ~rras1_n;
				end
				else if (!rwe_n)
				begin
					// column phase, upper cas is byte 0
					rep_valid <= 1'b1;
					rep_addr  <= {row, ra, chip, rucas_n};
					rep_data  <= rucas_n ? rd[7:0] : rd[15:8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/bridge_assertions.sv */
// protocol checks on the bridge DRAM strobes
// bound into z80_dram_bridge

`timescale 1ns/1ns
`default_nettype none

module bridge_assertions
(
	input wire fclk,
	input wire rst_n,
	input wire rwe_n,
	input wire rucas_n,
	input wire rlcas_n,
	input wire rras0_n,
	input wire rras1_n
);

	// read by the testbench for its final count
	int fail_count = 0;

	// only one bank open at a time
	a_one_ras: assert property (@(posedge fclk) disable iff (!rst_n)
		!(!rras0_n && !rras1_n))
	else
	begin
		fail_count++;
		$error("both RAS strobes low in the same cycle");
	end

	// cas needs a row opened the cycle before
	a_cas_after_ras: assert property (@(posedge fclk) disable iff (!rst_n)
		(!rucas_n || !rlcas_n) |-> !$past(rras0_n && rras1_n))
	else
	begin
		fail_count++;
		$error("CAS strobe low without RAS low in the previous cycle");
	end

	// write enable only inside a column cycle
	a_we_with_cas: assert property (@(posedge fclk) disable iff (!rst_n)
		!rwe_n |-> (!rucas_n || !rlcas_n))
	else
	begin
		fail_count++;
		$error("write enable low without a CAS strobe");
	end

endmodule

bind z80_dram_bridge bridge_assertions i_bridge_assertions (
	.fclk    (fclk),
	.rst_n   (rst_n),
	.rwe_n   (rwe_n),
	.rucas_n (rucas_n),
	.rlcas_n (rlcas_n),
	.rras0_n (rras0_n),
	.rras1_n (rras1_n)
);

`default_nettype wire

/* sim/tb.sv */
// testbench for the Z80 to DRAM write bridge with bus driver, LFSR,
// reference page mapping and compare process against the DRAM model

`timescale 1ns/1ns
`default_nettype none

module tb;

	localparam int FIFO_DEPTH       = 4;
	localparam int RESET_CYCLES     = 16;
	// about 125 bus cycles in the tests rounded up
	localparam int MAX_BUS_CYCLES   = 150;
	localparam int CYCLES_PER_WRITE = 11;
	// wr_n rise to CAS is under 10 cycles with an empty FIFO
	localparam int SETTLE_CYCLES    = 12;
	// a full FIFO empties at 4 cycles per write
	localparam int DRAIN_CYCLES     = FIFO_DEPTH * 4 + SETTLE_CYCLES;
	// twice the nominal run
	localparam int TIMEOUT_CYCLES   = 2 * (RESET_CYCLES + MAX_BUS_CYCLES * CYCLES_PER_WRITE);

	logic        fclk;
	logic        rst_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        wr_n;
	logic [15:0] a;
	logic [7:0]  d;
	wire         wait_n;
	wire  [9:0]  ra;
	wire  [15:0] rd;
	wire         rwe_n;
	wire         rucas_n;
	wire         rlcas_n;
	wire         rras0_n;
	wire         rras1_n;

	wire         rep_valid;
	wire  [21:0] rep_addr;
	wire  [7:0]  rep_data;

	// expected writes as {byte address, data}
	logic [29:0] exp_q [$];
	logic [29:0] head;

	// reference page table for windows 1..3
	logic [7:0]  ref_page [1:3];
	logic [31:0] lfsr;
	string       test_name;
	int          n_errors;
	int          n_checks;
	int          n_mapped;
	int          n_reports;
	int          n_asserts;
	int          cycle;

	z80_dram_bridge #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_z80_dram_bridge (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.mreq_n  (mreq_n),
		.iorq_n  (iorq_n),
		.wr_n    (wr_n),
		.a       (a),
		.d       (d),
		.wait_n  (wait_n),
		.ra      (ra),
		.rd      (rd),
		.rwe_n   (rwe_n),
		.rucas_n (rucas_n),
		.rlcas_n (rlcas_n),
		.rras0_n (rras0_n),
		.rras1_n (rras1_n)
	);

	dram_model i_dram_model (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.ra        (ra),
		.rd        (rd),
		.rwe_n     (rwe_n),
		.rucas_n   (rucas_n),
		.rlcas_n   (rlcas_n),
		.rras0_n   (rras0_n),
		.rras1_n   (rras1_n),
		.rep_valid (rep_valid),
		.rep_addr  (rep_addr),
		.rep_data  (rep_data)
	);

	initial
	begin
		fclk = 1'b0;
		forever #50 fclk = ~fclk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[31]};
		end
		return v;
	endfunction

	// bit 22 set when the write reaches DRAM
	function automatic logic [22:0] expected_addr(input logic [15:0] addr);
		if (addr[15:14] == 2'd0)
			return '0;
		return {1'b1, ref_page[addr[15:14]], addr[13:0]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// called just after a rising edge and returns on one
	task automatic bus_write(input logic mem, input logic [15:0] addr, input logic [7:0] data);
		a      <= addr;
		d      <= data;
		mreq_n <= ~mem;
		iorq_n <= mem;
		wr_n   <= 1'b0;
		repeat (4) @(posedge fclk);
		// z80 stretches the cycle while held
		while (!wait_n)
			@(posedge fclk);
		wr_n   <= 1'b1;
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		repeat (3) @(posedge fclk);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		logic [22:0] m;
		m = expected_addr(addr);
		if (m[22])
		begin
			exp_q.push_back({m[21:0], data});
			n_mapped++;
		end
		bus_write(1'b1, addr, data);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr[7:0] == 8'hF7 && addr[15:14] != 2'd0)
			ref_page[addr[15:14]] = data;
		bus_write(1'b0, addr, data);
	endtask

	// wait for the queue to empty within the drain limit
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES)
		begin
			@(posedge fclk);
			n++;
		end
		// room for stray writes
		repeat (SETTLE_CYCLES) @(posedge fclk);
	endtask

	// compare each DRAM write against the queue head
	initial
	begin
		forever
		begin
			@(posedge fclk);
			if (rep_valid)
			begin
				n_reports++;
				if (exp_q.size() == 0)
				begin
					n_errors++;
					$display("DRAM write to %h data %h arrived with none expected",
						rep_addr, rep_data);
				end
				else
				begin
					head = exp_q.pop_front();
					check_value("dram address", 32'(head[29:8]), 32'(rep_addr));
					check_value("dram data", 32'(head[7:0]), 32'(rep_data));
				end
			end
		end
	end

	always @(posedge fclk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d writes still expected", cycle, exp_q.size());
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [1:0]  win;
		logic [13:0] ofs;
		rst_n       = 1'b0;
		mreq_n      = 1'b1;
		iorq_n      = 1'b1;
		wr_n        = 1'b1;
		a           = '0;
		d           = '0;
		lfsr        = 32'd32;
		ref_page[1] = 8'd5;
		ref_page[2] = 8'd2;
		ref_page[3] = 8'd0;
		n_errors    = 0;
		n_checks    = 0;
		n_mapped    = 0;
		n_reports   = 0;
		cycle       = 0;
		test_name   = "reset";
		repeat (RESET_CYCLES) @(posedge fclk);
		rst_n <= 1'b1;
		@(posedge fclk);
		// wait_n, we, ucas, lcas, ras0, ras1
		check_value("strobes after reset", 32'h3f,
			32'({wait_n, rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n}));

		test_name = "reset map";
		mem_write(16'h4123, 8'hA5);
		mem_write(16'h8ABC, 8'h3C);
		mem_write(16'hC001, 8'h96);
		wait_drain();

		test_name = "page port";
		io_write(16'h80F7, 8'h3A);
		mem_write(16'h8010, 8'h11);
		mem_write(16'hBFFF, 8'h22);
		// window 0 and a foreign port leave the table alone
		io_write(16'h00F7, 8'h77);
		io_write(16'h40FE, 8'h44);
		mem_write(16'h4000, 8'h33);
		mem_write(16'h8002, 8'h44);
		io_write(16'hC0F7, 8'hFF);
		mem_write(16'hFFFF, 8'h55);
		wait_drain();

		test_name = "rom window";
		mem_write(16'h0000, 8'h01);
		mem_write(16'h1234, 8'h02);
		mem_write(16'h3FFF, 8'h03);
		mem_write(16'h4444, 8'h04);
		wait_drain();
		check_value("report count", 32'(n_mapped), 32'(n_reports));

		test_name = "byte lanes";
		for (int i = 0; i < 4; i++)
		begin
			mem_write(16'hC100 + 16'(i), 8'h10 + 8'(i));
			mem_write(16'h4FFC + 16'(i), 8'hE0 + 8'(i));
		end
		wait_drain();

		test_name = "random";
		for (int k = 0; k < 100; k++)
		begin
			r = rand_bits(2);
			while (r[1:0] == 2'd0)
			begin
				r = rand_bits(2);
			end
			win = r[1:0];
			r   = rand_bits(14);
			ofs = r[13:0];
			r   = rand_bits(8);
			mem_write({win, ofs}, r[7:0]);
		end
		wait_drain();

		test_name = "final";
		check_value("writes left in queue", 32'd0, 32'(exp_q.size()));
		check_value("report count", 32'(n_mapped), 32'(n_reports));
		n_asserts = i_z80_dram_bridge.i_bridge_assertions.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d, dram writes %0d",
			n_checks, n_errors, n_asserts, n_reports);
		if (n_errors == 0 && n_asserts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
verilog/z80_pkg.sv
verilog/dram_pkg.sv
verilog/z80_bus_capture.sv
verilog/cmd_fifo.sv
verilog/dram_writer.sv
verilog/z80_dram_bridge.sv
sim/dram_model.sv
sim/bridge_assertions.sv
sim/tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Z80 to DRAM bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f sources.f --top-module tb -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	exit 1
fi
exit 0
